//--- logic/la_cfg_pkg.sv
package la_cfg_pkg;

    localparam int SAMPLE_W         = 8;     // analyzer channels
    localparam int SAMPLES_PER_WORD = 4;
    localparam int WORD_W           = SAMPLE_W * SAMPLES_PER_WORD;
    localparam int LANE_W           = $clog2(SAMPLES_PER_WORD);

    // memory addresses count words, not bytes
    localparam int ADDR_W           = 10;
    localparam int MEM_DEPTH        = 1 << ADDR_W;

    localparam int LEN_W            = 4;     // beats minus one
    localparam int BURST_MAX        = 1 << LEN_W;

    localparam int IN_BUF_DEPTH     = 32;
    localparam int OUT_BUF_DEPTH    = 32;
    localparam int IN_PTR_W         = $clog2(IN_BUF_DEPTH);
    localparam int OUT_PTR_W        = $clog2(OUT_BUF_DEPTH);

    localparam int COUNT_W          = 12;    // sample_num width, in words
    localparam int DIV_W            = 4;

    typedef logic [SAMPLE_W-1:0] sample_t;
    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [LEN_W-1:0]    len_t;

endpackage

//--- logic/la_ctrl_pkg.sv
package la_ctrl_pkg;

    typedef enum logic [1:0] {
        TRIG_NOW,     // start on the first sample
        TRIG_RISE,
        TRIG_FALL,
        TRIG_HIGH
    } trig_mode_e;

    typedef enum logic [2:0] {
        WR_IDLE,
        WR_CMD,
        WR_DATA,
        WR_DONE
    } wr_state_e;

    typedef enum logic [2:0] {
        RD_IDLE,
        RD_CMD,
        RD_DATA,
        RD_DONE
    } rd_state_e;

endpackage

//--- logic/burst_if.sv
`timescale 1ns/1ps

// write bursts toward the word memory
interface wr_burst_if;
    logic                  cmd_valid;
    la_cfg_pkg::addr_t     cmd_addr;
    la_cfg_pkg::len_t      cmd_len;
    logic                  cmd_ready;
    la_cfg_pkg::word_t     data;
    logic                  data_valid;
    logic                  data_last;
    logic                  data_ready;

    modport wr_master (output cmd_valid, cmd_addr, cmd_len, data, data_valid, data_last,
                       input  cmd_ready, data_ready);
    modport wr_slave  (input  cmd_valid, cmd_addr, cmd_len, data, data_valid, data_last,
                       output cmd_ready, data_ready);
endinterface

// read bursts without beat backpressure
interface rd_burst_if;
    logic                  cmd_valid;
    la_cfg_pkg::addr_t     cmd_addr;
    la_cfg_pkg::len_t      cmd_len;
    logic                  cmd_ready;
    la_cfg_pkg::word_t     data;
    logic                  data_valid;
    logic                  data_last;

    modport rd_master (output cmd_valid, cmd_addr, cmd_len,
                       input  cmd_ready, data, data_valid, data_last);
    modport rd_slave  (input  cmd_valid, cmd_addr, cmd_len,
                       output cmd_ready, data, data_valid, data_last);
endinterface

//--- logic/sample_capture.sv
`timescale 1ns/1ps

module sample_capture (
    input  logic                           clk_ip,
    input  logic                           rst_n,
    input  logic                           sample_run,
    input  la_ctrl_pkg::trig_mode_e        trig_mode,
    input  logic [2:0]                     trig_channel,
    input  logic [la_cfg_pkg::DIV_W-1:0]   sample_div,
    input  logic [la_cfg_pkg::COUNT_W-1:0] sample_num,   // words
    input  la_cfg_pkg::sample_t            din,
    input  logic                           read_done,
    output la_cfg_pkg::word_t              word,
    output logic                           word_valid,
    input  logic                           word_ready,
    output logic                           cap_done,
    output logic                           busy
);
    logic [2:0]                      run_sync;     // two sync stages + edge history
    logic                            read_done_q;
    logic                            clear;
    logic                            armed;        // waiting for trigger
    logic                            running;
    logic                            overflow;
    logic                            trig_hit;
    logic                            take;
    logic                            word_end;
    la_cfg_pkg::sample_t             din_q;
    logic [la_cfg_pkg::DIV_W-1:0]    div_cnt;
    logic [la_cfg_pkg::LANE_W-1:0]   lane;
    la_cfg_pkg::word_t               pack;
    logic [la_cfg_pkg::COUNT_W-1:0]  made_cnt;
    logic [la_cfg_pkg::COUNT_W-1:0]  acc_cnt;

    assign clear    = read_done & ~read_done_q;
    assign busy     = armed | running;
    assign take     = (armed & trig_hit) | (running & (div_cnt == sample_div));
    assign word_end = take & (&lane);   // lane count is a power of two

    // compare each sample with the one before it
    always_comb begin
        case (trig_mode)
            la_ctrl_pkg::TRIG_RISE: trig_hit = din[trig_channel] & ~din_q[trig_channel];
            la_ctrl_pkg::TRIG_FALL: trig_hit = ~din[trig_channel] & din_q[trig_channel];
            la_ctrl_pkg::TRIG_HIGH: trig_hit = din[trig_channel];
            default:                trig_hit = 1'b1;
        endcase
    end

    always_ff @(posedge clk_ip) begin
        din_q <= din;
        if (take) pack <= {din, pack[la_cfg_pkg::WORD_W-1:la_cfg_pkg::SAMPLE_W]};
        if (word_end) word <= {din, pack[la_cfg_pkg::WORD_W-1:la_cfg_pkg::SAMPLE_W]};
    end

    always_ff @(posedge clk_ip or negedge rst_n) begin
        if (!rst_n) begin
            run_sync    <= '0;
            read_done_q <= 1'b0;
            armed       <= 1'b0;
            running     <= 1'b0;
            overflow    <= 1'b0;
            div_cnt     <= '0;
            lane        <= '0;
            made_cnt    <= '0;
            acc_cnt     <= '0;
            word_valid  <= 1'b0;
            cap_done    <= 1'b0;
        end else begin
            run_sync    <= {run_sync[1:0], sample_run};
            read_done_q <= read_done;
            if (clear) begin
                armed      <= 1'b0;
                running    <= 1'b0;
                overflow   <= 1'b0;
                div_cnt    <= '0;
                lane       <= '0;
                made_cnt   <= '0;
                acc_cnt    <= '0;
                word_valid <= 1'b0;
                cap_done   <= 1'b0;
            end else begin
                if (run_sync[1] & ~run_sync[2] & ~busy & ~cap_done) armed <= 1'b1;
                if (armed & trig_hit) begin
                    armed   <= 1'b0;
                    running <= 1'b1;
                end
                if (take) div_cnt <= '0;
                else if (running) div_cnt <= div_cnt + 1'b1;
                if (take) lane <= lane + 1'b1;
                if (word_end) begin
                    made_cnt <= made_cnt + 1'b1;
                    if (made_cnt + 1'b1 == sample_num) running <= 1'b0;
                    if (word_valid & ~word_ready) overflow <= 1'b1;   // sticky
                end
                if (word_end) word_valid <= 1'b1;
                else if (word_ready) word_valid <= 1'b0;
                if (word_valid & word_ready) begin
                    acc_cnt <= acc_cnt + 1'b1;
                    if (acc_cnt + 1'b1 == sample_num) cap_done <= 1'b1;
                end
            end
        end
    end

    a_no_overflow: assert property (@(posedge clk_ip) disable iff (!rst_n) !overflow)
        else $error("capture word replaced before the writer took it");

endmodule

//--- logic/burst_writer.sv
`timescale 1ns/1ps

module burst_writer (
    input  logic                clk_ip,
    input  logic                rst_n,
    input  la_cfg_pkg::word_t   word,
    input  logic                word_valid,
    output logic                word_ready,
    input  logic                cap_done,
    input  logic                read_done,
    wr_burst_if.wr_master       wr,
    output la_cfg_pkg::addr_t   wr_ptr,       // words committed
    output logic                all_written
);
    la_cfg_pkg::word_t                buf_mem [la_cfg_pkg::IN_BUF_DEPTH];
    logic [la_cfg_pkg::IN_PTR_W-1:0]  head;
    logic [la_cfg_pkg::IN_PTR_W-1:0]  tail;
    logic [la_cfg_pkg::IN_PTR_W:0]    count;
    la_ctrl_pkg::wr_state_e           state;
    la_cfg_pkg::len_t                 len_q;
    la_cfg_pkg::len_t                 beat;
    logic                             read_done_q;
    logic                             clear;
    logic                             push;
    logic                             pop;

    assign clear       = read_done & ~read_done_q;
    assign word_ready  = (count != la_cfg_pkg::IN_BUF_DEPTH);
    assign push        = word_valid & word_ready;
    assign pop         = wr.data_valid & wr.data_ready;
    assign all_written = cap_done & (count == '0) & (state == la_ctrl_pkg::WR_IDLE);

    assign wr.cmd_valid  = (state == la_ctrl_pkg::WR_CMD);
    assign wr.cmd_addr   = wr_ptr;
    assign wr.cmd_len    = len_q;
    assign wr.data       = buf_mem[head];
    assign wr.data_valid = (state == la_ctrl_pkg::WR_DATA);
    assign wr.data_last  = (beat == len_q);

    always_ff @(posedge clk_ip) begin
        if (push) buf_mem[tail] <= word;
    end

    always_ff @(posedge clk_ip or negedge rst_n) begin
        if (!rst_n) begin
            state       <= la_ctrl_pkg::WR_IDLE;
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            len_q       <= '0;
            beat        <= '0;
            wr_ptr      <= '0;
            read_done_q <= 1'b0;
        end else begin
            read_done_q <= read_done;
            if (clear) begin
                state  <= la_ctrl_pkg::WR_IDLE;
                head   <= '0;
                tail   <= '0;
                count  <= '0;
                wr_ptr <= '0;
            end else begin
                if (push) tail <= tail + 1'b1;
                if (pop) head <= head + 1'b1;
                case ({push, pop})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;
                endcase
                case (state)
                    la_ctrl_pkg::WR_IDLE: begin
                        // full burst, or flush what is left at the end
                        if (count >= la_cfg_pkg::BURST_MAX || (cap_done && count != '0)) begin
                            len_q <= (count >= la_cfg_pkg::BURST_MAX) ? '1 :
                                     la_cfg_pkg::len_t'(count - 1'b1);
                            state <= la_ctrl_pkg::WR_CMD;
                        end
                    end
                    la_ctrl_pkg::WR_CMD: begin
                        beat <= '0;
                        if (wr.cmd_ready) state <= la_ctrl_pkg::WR_DATA;
                    end
                    la_ctrl_pkg::WR_DATA: begin
                        if (pop) begin
                            beat <= beat + 1'b1;
                            if (wr.data_last) state <= la_ctrl_pkg::WR_DONE;
                        end
                    end
                    la_ctrl_pkg::WR_DONE: begin
                        wr_ptr <= wr_ptr + len_q + 1'b1;
                        state  <= la_ctrl_pkg::WR_IDLE;
                    end
                    default: state <= la_ctrl_pkg::WR_IDLE;
                endcase
            end
        end
    end

    // latched length must still fit the buffered words
    a_len_covered: assert property (@(posedge clk_ip) disable iff (!rst_n)
        wr.cmd_valid |-> (count > wr.cmd_len));

endmodule

//--- logic/burst_reader.sv
`timescale 1ns/1ps

module burst_reader (
    input  logic                clk_ip,
    input  logic                rst_n,
    rd_burst_if.rd_master       rd,
    input  la_cfg_pkg::addr_t   wr_ptr,
    input  logic                all_written,
    input  logic                read_done,
    output la_cfg_pkg::word_t   out_data,
    output logic                out_valid,
    input  logic                out_ready
);
    la_cfg_pkg::word_t                 buf_mem [la_cfg_pkg::OUT_BUF_DEPTH];
    logic [la_cfg_pkg::OUT_PTR_W-1:0]  head;
    logic [la_cfg_pkg::OUT_PTR_W-1:0]  tail;
    logic [la_cfg_pkg::OUT_PTR_W:0]    count;
    la_ctrl_pkg::rd_state_e            state;
    la_cfg_pkg::addr_t                 rd_ptr;
    la_cfg_pkg::addr_t                 remain;      // written but not yet requested
    la_cfg_pkg::len_t                  len_q;
    logic                              room;
    logic                              start;
    logic                              read_done_q;
    logic                              clear;
    logic                              pop;

    assign clear     = read_done & ~read_done_q;
    assign remain    = wr_ptr - rd_ptr;
    assign room      = (la_cfg_pkg::OUT_BUF_DEPTH - count) >= la_cfg_pkg::BURST_MAX;
    // wait for a full burst unless the writer has finished
    assign start     = out_ready & room &
                       ((remain >= la_cfg_pkg::BURST_MAX) | (all_written & (remain != '0)));
    assign pop       = out_valid & out_ready;
    assign out_valid = (count != '0);
    assign out_data  = buf_mem[head];

    assign rd.cmd_valid = (state == la_ctrl_pkg::RD_CMD);
    assign rd.cmd_addr  = rd_ptr;
    assign rd.cmd_len   = len_q;

    always_ff @(posedge clk_ip) begin
        if (rd.data_valid) buf_mem[tail] <= rd.data;
    end

    always_ff @(posedge clk_ip or negedge rst_n) begin
        if (!rst_n) begin
            state       <= la_ctrl_pkg::RD_IDLE;
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            rd_ptr      <= '0;
            len_q       <= '0;
            read_done_q <= 1'b0;
        end else begin
            read_done_q <= read_done;
            if (clear) begin
                state  <= la_ctrl_pkg::RD_IDLE;
                head   <= '0;
                tail   <= '0;
                count  <= '0;
                rd_ptr <= '0;
            end else begin
                if (rd.data_valid) tail <= tail + 1'b1;
                if (pop) head <= head + 1'b1;
                case ({rd.data_valid, pop})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;
                endcase
                case (state)
                    la_ctrl_pkg::RD_IDLE: begin
                        if (start) begin
                            len_q <= (remain >= la_cfg_pkg::BURST_MAX) ? '1 :
                                     la_cfg_pkg::len_t'(remain - 1'b1);
                            state <= la_ctrl_pkg::RD_CMD;
                        end
                    end
                    la_ctrl_pkg::RD_CMD: begin
                        if (rd.cmd_ready) begin
                            rd_ptr <= rd_ptr + len_q + 1'b1;
                            state  <= la_ctrl_pkg::RD_DATA;
                        end
                    end
                    la_ctrl_pkg::RD_DATA: begin
                        if (rd.data_valid & rd.data_last) state <= la_ctrl_pkg::RD_DONE;
                    end
                    default: state <= la_ctrl_pkg::RD_IDLE;   // RD_DONE
                endcase
            end
        end
    end

    a_rd_behind_wr: assert property (@(posedge clk_ip) disable iff (!rst_n)
        rd.cmd_valid |-> (({1'b0, rd.cmd_addr} + rd.cmd_len) < {1'b0, wr_ptr}));

endmodule

//--- logic/sample_ram.sv
`timescale 1ns/1ps

module sample_ram (
    input  logic           clk_ip,
    input  logic           rst_n,
    wr_burst_if.wr_slave   wr,
    rd_burst_if.rd_slave   rd
);
    la_cfg_pkg::word_t   mem [la_cfg_pkg::MEM_DEPTH];
    logic                wr_open;
    la_cfg_pkg::addr_t   wr_addr;
    logic                rd_open;     // address stage of the read pipe
    la_cfg_pkg::addr_t   rd_addr;
    la_cfg_pkg::len_t    rd_left;
    logic                idle;
    logic                wr_accept;
    logic                rd_accept;
    logic                wr_beat;

    assign idle          = ~wr_open & ~rd_open;
    assign wr.cmd_ready  = idle;
    assign rd.cmd_ready  = idle & ~wr.cmd_valid;   // writes win
    assign wr.data_ready = wr_open;
    assign wr_accept     = wr.cmd_valid & wr.cmd_ready;
    assign rd_accept     = rd.cmd_valid & rd.cmd_ready;
    assign wr_beat       = wr.data_valid & wr.data_ready;

    always_ff @(posedge clk_ip) begin
        if (wr_beat) mem[wr_addr] <= wr.data;
        rd.data <= mem[rd_addr];               // data stage
    end

    always_ff @(posedge clk_ip or negedge rst_n) begin
        if (!rst_n) begin
            wr_open       <= 1'b0;
            wr_addr       <= '0;
            rd_open       <= 1'b0;
            rd_addr       <= '0;
            rd_left       <= '0;
            rd.data_valid <= 1'b0;
            rd.data_last  <= 1'b0;
        end else begin
            if (wr_accept) begin
                wr_open <= 1'b1;
                wr_addr <= wr.cmd_addr;
            end else if (wr_beat) begin
                wr_addr <= wr_addr + 1'b1;
                if (wr.data_last) wr_open <= 1'b0;
            end
            if (rd_accept) begin
                rd_open <= 1'b1;
                rd_addr <= rd.cmd_addr;
                rd_left <= rd.cmd_len;
            end else if (rd_open) begin
                rd_addr <= rd_addr + 1'b1;
                rd_left <= rd_left - 1'b1;
                if (rd_left == '0) rd_open <= 1'b0;
            end
            rd.data_valid <= rd_open;
            rd.data_last  <= rd_open & (rd_left == '0);
        end
    end

    // no new command of a kind while its burst is open
    a_wr_single: assert property (@(posedge clk_ip) disable iff (!rst_n)
        wr_open |-> !wr.cmd_valid);
    a_rd_single: assert property (@(posedge clk_ip) disable iff (!rst_n)
        rd_open |-> !rd.cmd_valid);
    // first read beat two cycles out
    a_rd_latency: assert property (@(posedge clk_ip) disable iff (!rst_n)
        rd_accept |-> ##2 rd.data_valid);

endmodule

//--- logic/la_top.sv
`timescale 1ns/1ps

module la_top (
    input  logic                           clk_ip,
    input  logic                           rst_n,
    input  logic                           sample_run,
    input  la_ctrl_pkg::trig_mode_e        trig_mode,
    input  logic [2:0]                     trig_channel,
    input  logic [la_cfg_pkg::DIV_W-1:0]   sample_div,
    input  logic [la_cfg_pkg::COUNT_W-1:0] sample_num,
    input  la_cfg_pkg::sample_t            din,
    input  logic                           read_done,
    output la_cfg_pkg::word_t              out_data,
    output logic                           out_valid,
    input  logic                           out_ready,
    output logic                           capture_done,
    output logic                           busy
);
    la_cfg_pkg::word_t   word;
    logic                word_valid;
    logic                word_ready;
    logic                cap_done;
    la_cfg_pkg::addr_t   wr_ptr;

    wr_burst_if wr_bus ();
    rd_burst_if rd_bus ();

    sample_capture u_capture (
        .clk_ip       (clk_ip),
        .rst_n        (rst_n),
        .sample_run   (sample_run),
        .trig_mode    (trig_mode),
        .trig_channel (trig_channel),
        .sample_div   (sample_div),
        .sample_num   (sample_num),
        .din          (din),
        .read_done    (read_done),
        .word         (word),
        .word_valid   (word_valid),
        .word_ready   (word_ready),
        .cap_done     (cap_done),
        .busy         (busy)
    );

    burst_writer u_writer (
        .clk_ip      (clk_ip),
        .rst_n       (rst_n),
        .word        (word),
        .word_valid  (word_valid),
        .word_ready  (word_ready),
        .cap_done    (cap_done),
        .read_done   (read_done),
        .wr          (wr_bus.wr_master),
        .wr_ptr      (wr_ptr),
        .all_written (capture_done)
    );

    burst_reader u_reader (
        .clk_ip      (clk_ip),
        .rst_n       (rst_n),
        .rd          (rd_bus.rd_master),
        .wr_ptr      (wr_ptr),
        .all_written (capture_done),
        .read_done   (read_done),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .out_ready   (out_ready)
    );

    sample_ram u_ram (
        .clk_ip (clk_ip),
        .rst_n  (rst_n),
        .wr     (wr_bus.wr_slave),
        .rd     (rd_bus.rd_slave)
    );

endmodule

//--- verif/la_tb.sv
`timescale 1ns/1ps

module la_tb;

    localparam int num_rows   = 7;
    localparam int wait_limit = 2000;   // cycles without progress
    localparam int drain_time = 40;     // idle cycles watched for stray words

    typedef struct packed {
        la_ctrl_pkg::trig_mode_e          mode;
        logic [2:0]                       chan;
        logic [la_cfg_pkg::DIV_W-1:0]     div;
        logic [la_cfg_pkg::COUNT_W-1:0]   num;    // words
        logic                             stall;  // random out_ready
    } test_row_t;

    logic                           clk_ip;
    logic                           rst_n;
    logic                           sample_run;
    la_ctrl_pkg::trig_mode_e        trig_mode;
    logic [2:0]                     trig_channel;
    logic [la_cfg_pkg::DIV_W-1:0]   sample_div;
    logic [la_cfg_pkg::COUNT_W-1:0] sample_num;
    la_cfg_pkg::sample_t            din;
    logic                           read_done;
    la_cfg_pkg::word_t              out_data;
    logic                           out_valid;
    logic                           out_ready;
    logic                           capture_done;
    logic                           busy;

    test_row_t  rows [num_rows];
    logic [7:0] samples [$];    // bytes in arrival order
    int         errors;
    int         tests_ok;
    logic       timed_out;

    la_top uut (
        .clk_ip       (clk_ip),
        .rst_n        (rst_n),
        .sample_run   (sample_run),
        .trig_mode    (trig_mode),
        .trig_channel (trig_channel),
        .sample_div   (sample_div),
        .sample_num   (sample_num),
        .din          (din),
        .read_done    (read_done),
        .out_data     (out_data),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .capture_done (capture_done),
        .busy         (busy)
    );

    always #10 clk_ip = ~clk_ip;

    // free-running sample source
    always @(posedge clk_ip) begin
        #1;
        din = din + 1'b1;
    end

    task automatic bad_value(input string name, input logic [31:0] got, input logic [31:0] want);
        $display("ERR %s: got %h, expected %h", name, got, want);
        errors++;
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: no progress while waiting for %s", what);
        timed_out = 1'b1;
    endtask

    task automatic start_capture(input test_row_t row);
        @(posedge clk_ip);
        #1;
        trig_mode    = row.mode;
        trig_channel = row.chan;
        sample_div   = row.div;
        sample_num   = row.num;
        sample_run   = 1'b1;
        repeat (3) @(posedge clk_ip);
        #1;
        sample_run = 1'b0;
    endtask

    task automatic collect_words(input test_row_t row);
        int idle;
        int extra;
        idle  = 0;
        extra = 0;
        samples.delete();
        while (samples.size() < row.num * 4 && !timed_out) begin
            @(posedge clk_ip);
            #1;
            out_ready = row.stall ? (($urandom % 3) != 0) : 1'b1;
            @(negedge clk_ip);
            if (out_valid && out_ready) begin
                // oldest sample sits in the low byte
                for (int b = 0; b < la_cfg_pkg::SAMPLES_PER_WORD; b++)
                    samples.push_back(out_data[b*la_cfg_pkg::SAMPLE_W +: la_cfg_pkg::SAMPLE_W]);
                idle = 0;
            end else begin
                idle++;
                if (idle > wait_limit) report_timeout("out_valid");
            end
        end
        @(posedge clk_ip);
        #1;
        out_ready = 1'b1;
        repeat (drain_time) begin
            @(negedge clk_ip);
            if (out_valid) extra++;
        end
        if (!timed_out) begin
            assert (extra == 0) else bad_value("out_valid word count", row.num + extra, row.num);
        end
    endtask

    task automatic check_samples(input test_row_t row);
        logic [7:0] first;
        logic [7:0] prev;
        logic [7:0] step;
        logic [7:0] want;
        int         c;
        first = samples[0];
        prev  = first - 8'd1;      // din advances by one per cycle
        step  = 8'(row.div) + 8'd1;
        c     = row.chan;
        case (row.mode)
            la_ctrl_pkg::TRIG_RISE: begin
                assert ({prev[c], first[c]} == 2'b01)
                    else bad_value("out_data trigger bits", {prev[c], first[c]}, 2'b01);
            end
            la_ctrl_pkg::TRIG_FALL: begin
                assert ({prev[c], first[c]} == 2'b10)
                    else bad_value("out_data trigger bits", {prev[c], first[c]}, 2'b10);
            end
            la_ctrl_pkg::TRIG_HIGH: begin
                assert (first[c] == 1'b1) else bad_value("out_data trigger bit", first[c], 1'b1);
            end
            default: ;
        endcase
        for (int i = 1; i < samples.size(); i++) begin
            want = samples[i-1] + step;
            assert (samples[i] == want) else bad_value("out_data sample", samples[i], want);
        end
    endtask

    task automatic wait_capture_done();
        int n;
        n = 0;
        @(negedge clk_ip);
        while (!capture_done && !timed_out) begin
            @(negedge clk_ip);
            n++;
            if (n > wait_limit) report_timeout("capture_done");
        end
    endtask

    task automatic acknowledge_read();
        @(posedge clk_ip);
        #1;
        read_done = 1'b1;
        repeat (2) @(posedge clk_ip);
        #1;
        read_done = 1'b0;
        @(negedge clk_ip);
        assert (capture_done == 1'b0) else bad_value("capture_done", capture_done, 0);
        assert (busy == 1'b0) else bad_value("busy", busy, 0);
    endtask

    initial begin
        int err_mark;
        void'($urandom(49));
        clk_ip       = 1'b0;
        rst_n        = 1'b0;
        sample_run   = 1'b0;
        trig_mode    = la_ctrl_pkg::TRIG_NOW;
        trig_channel = '0;
        sample_div   = '0;
        sample_num   = '0;
        din          = '0;
        read_done    = 1'b0;
        out_ready    = 1'b1;
        errors       = 0;
        tests_ok     = 0;
        timed_out    = 1'b0;

        // mode, channel, divider, words, stall
        rows[0] = '{la_ctrl_pkg::TRIG_NOW,  3'd0, 4'd0,  12'd4,  1'b0};
        rows[1] = '{la_ctrl_pkg::TRIG_RISE, 3'd3, 4'd1,  12'd8,  1'b0};
        rows[2] = '{la_ctrl_pkg::TRIG_FALL, 3'd5, 4'd2,  12'd5,  1'b0};
        rows[3] = '{la_ctrl_pkg::TRIG_HIGH, 3'd7, 4'd0,  12'd3,  1'b0};
        rows[4] = '{la_ctrl_pkg::TRIG_NOW,  3'd0, 4'd3,  12'd20, 1'b1};
        rows[5] = '{la_ctrl_pkg::TRIG_NOW,  3'd0, 4'd0,  12'd40, 1'b0};   // full + partial bursts
        rows[6] = '{la_ctrl_pkg::TRIG_RISE, 3'd1, 4'd15, 12'd2,  1'b1};

        repeat (5) @(posedge clk_ip);
        #1;
        rst_n = 1'b1;

        for (int i = 0; i < num_rows; i++) begin
            err_mark = errors;
            start_capture(rows[i]);
            collect_words(rows[i]);
            if (!timed_out) check_samples(rows[i]);
            if (!timed_out) wait_capture_done();
            if (!timed_out) acknowledge_read();
            if (errors == err_mark && !timed_out) begin
                tests_ok++;
                $display("test %0d mode %0d ch %0d div %0d words %0d: ok", i, rows[i].mode,
                         rows[i].chan, rows[i].div, rows[i].num);
            end else begin
                $display("test %0d mode %0d ch %0d div %0d words %0d: failed", i, rows[i].mode,
                         rows[i].chan, rows[i].div, rows[i].num);
            end
            if (timed_out) break;
        end

        $display("summary: %0d of %0d tests ok, %0d value errors", tests_ok, num_rows, errors);
        if (errors == 0 && !timed_out && tests_ok == num_rows) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
logic/la_cfg_pkg.sv
logic/la_ctrl_pkg.sv
logic/burst_if.sv
logic/sample_capture.sv
logic/burst_writer.sv
logic/burst_reader.sv
logic/sample_ram.sv
logic/la_top.sv
verif/la_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module la_tb -f sim.f -o la_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/la_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -Fxq "ALL TESTS PASSED"; then
    exit 0
fi
exit 1
